// File: src/quirePkg.sv
// Sizes, register map and control bits for the posit dot-product unit.
// Modules pull these in with a wildcard import in their header.
package quirePkg;

  // Largest magnitude of a posit scale, reached by maxpos and minpos
  function automatic int maxScale(input int width, input int es);
    return (width - 2) << es;
  endfunction

  // Signed scale width
  function automatic int scaleBits(input int width, input int es);
    return $clog2(maxScale(width, es) + 1) + 1;
  endfunction

  // Fraction width without the hidden bit
  function automatic int fracBits(input int width, input int es);
    return width - 3 - es;
  endfunction

  function automatic int quireFracBits(input int width, input int es);
    return 2 * maxScale(width, es);
  endfunction

  // Integer part including sign, carry guard and extra overflow bits
  function automatic int quireIntBits(input int width, input int es, input int overflow);
    return 2 * maxScale(width, es) + 2 + overflow;
  endfunction

  function automatic int quireBits(input int width, input int es, input int overflow);
    return quireIntBits(width, es, overflow) + quireFracBits(width, es);
  endfunction

  // APB register offsets
  localparam logic [7:0] RegOpA = 8'h00;
  localparam logic [7:0] RegOpB = 8'h04;
  localparam logic [7:0] RegCtrl = 8'h08;
  localparam logic [7:0] RegResult = 8'h0C;

  // RegCtrl bits, clear wins over acc
  localparam int CtrlClear = 0;
  localparam int CtrlAcc = 1;

endpackage

// File: src/positUnpackedIf.sv
`timescale 1ns/1ps
// One decoded posit passed between datapath blocks.
// The block that produces it takes src, the block that uses it takes snk.
interface positUnpackedIf import quirePkg::*; #(
  parameter int WIDTH = 8,
  parameter int ES = 1
) ();

  logic isNaR;
  logic isZero;
  logic sign;
  logic signed [scaleBits(WIDTH, ES)-1:0] scale;
  logic [fracBits(WIDTH, ES)-1:0] frac;

  modport src (output isNaR, isZero, sign, scale, frac);
  modport snk (input isNaR, isZero, sign, scale, frac);

endinterface

// File: src/positDecode.sv
`timescale 1ns/1ps
// Splits a packed posit into flags, signed scale and fraction.
// Negative posits are negated first so the regime is read from the magnitude.
module positDecode import quirePkg::*; #(
  parameter int WIDTH = 8,
  parameter int ES = 1
) (
  input  logic [WIDTH-1:0] in,
  positUnpackedIf.src      out
);

  localparam int ScaleW = scaleBits(WIDTH, ES);
  localparam int FracW = fracBits(WIDTH, ES);
  localparam int RunW = $clog2(WIDTH) + 1;

  logic [WIDTH-1:0] mag;
  logic [WIDTH-2:0] body;
  logic [WIDTH-2:0] rest;
  logic [RunW-1:0] run;
  logic [ES-1:0] expField;
  logic signed [ScaleW-1:0] regime;

  assign mag = in[WIDTH-1] ? -in : in;
  assign body = mag[WIDTH-2:0];

  // Regime run length, highest bit that differs from the first one
  always_comb begin
    run = RunW'(WIDTH - 1);
    for (int i = 0; i < WIDTH - 1; i++) begin
      if (body[i] != body[WIDTH-2]) begin
        run = RunW'(WIDTH - 2 - i);
      end
    end
  end

  always_comb begin
    // Drop the run and its terminator, missing bits read as zero
    rest = body << (run + 1'b1);
    expField = rest[WIDTH-2 -: ES];
    regime = body[WIDTH-2] ? ScaleW'(run) - ScaleW'(1) : -ScaleW'(run);

    out.isNaR = (in == {1'b1, {(WIDTH-1){1'b0}}});
    out.isZero = (in == '0);
    out.sign = in[WIDTH-1];
    out.scale = (regime <<< ES) + ScaleW'(expField);
    out.frac = rest[WIDTH-2-ES -: FracW];
  end

endmodule

// File: src/positMulQuire.sv
`timescale 1ns/1ps
// Exact product of two decoded posits as a signed fixed-point quire term.
// The LSB of the term weighs 2^-quireFracBits, so no product bit is lost.
module positMulQuire import quirePkg::*; #(
  parameter int WIDTH = 8,
  parameter int ES = 1,
  parameter int OVERFLOW = 0
) (
  positUnpackedIf.snk a,
  positUnpackedIf.snk b,
  output logic signed [quireBits(WIDTH, ES, OVERFLOW)-1:0] term,
  output logic termNaR
);

  localparam int FracW = fracBits(WIDTH, ES);
  localparam int QuireW = quireBits(WIDTH, ES, OVERFLOW);
  localparam int QuireFrac = quireFracBits(WIDTH, ES);
  localparam int ProdW = 2 * (FracW + 1);
  localparam int ExtW = QuireW + 2 * FracW;
  localparam int ShiftW = $clog2(ExtW);

  logic [ProdW-1:0] prod;
  logic [ShiftW-1:0] shift;
  logic [ExtW-1:0] aligned;
  logic [QuireW-1:0] mag;

  always_comb begin
    prod = {1'b1, a.frac} * {1'b1, b.frac};
    // Never negative since each scale is at least minus half the quire fraction
    shift = ShiftW'(int'(a.scale) + int'(b.scale) + QuireFrac);
    aligned = ExtW'(prod) << shift;
    // Product carries 2*FracW fraction bits of its own
    mag = aligned[ExtW-1 -: QuireW];

    termNaR = a.isNaR || b.isNaR;
    if (termNaR || a.isZero || b.isZero) begin
      term = '0;
    end else if (a.sign ^ b.sign) begin
      term = -$signed(mag);
    end else begin
      term = $signed(mag);
    end
  end

endmodule

// File: src/quireAccum.sv
`timescale 1ns/1ps
// Kulisch quire register.
// Each acc adds one exact term in two's complement, NaR holds until clear.
module quireAccum import quirePkg::*; #(
  parameter int WIDTH = 8,
  parameter int ES = 1,
  parameter int OVERFLOW = 0
) (
  input  logic clk,
  input  logic rst,
  input  logic clear,
  input  logic acc,
  input  logic signed [quireBits(WIDTH, ES, OVERFLOW)-1:0] term,
  input  logic termNaR,
  output logic signed [quireBits(WIDTH, ES, OVERFLOW)-1:0] quire,
  output logic quireNaR
);

  always_ff @(posedge clk) begin
    if (rst) begin
      quire <= '0;
      quireNaR <= 1'b0;
    end else if (clear) begin
      quire <= '0;
      quireNaR <= 1'b0;
    end else if (acc) begin
      // Wide integer part keeps long sums from wrapping
      quire <= quire + term;
      quireNaR <= quireNaR | termNaR;
    end
  end

endmodule

// File: src/quireToPosit.sv
`timescale 1ns/1ps
// Normalizes the quire into a decoded posit plus rounding bits.
// Frac holds only the bits the posit can keep at this scale, the rest feed
// trailing and sticky. Where exponent bits get cut, the bits pick the nearer value.
module quireToPosit import quirePkg::*; #(
  parameter int WIDTH = 8,
  parameter int ES = 1,
  parameter int OVERFLOW = 0
) (
  input  logic signed [quireBits(WIDTH, ES, OVERFLOW)-1:0] quire,
  input  logic quireNaR,
  positUnpackedIf.src out,
  output logic [1:0] trailing,
  output logic sticky
);

  localparam int QuireW = quireBits(WIDTH, ES, OVERFLOW);
  localparam int QuireFrac = quireFracBits(WIDTH, ES);
  localparam int MaxScale = maxScale(WIDTH, ES);
  localparam int ScaleW = scaleBits(WIDTH, ES);
  localparam int FracW = fracBits(WIDTH, ES);
  localparam int FrW = QuireW - 1;

  logic [QuireW-1:0] mag;
  logic [FrW-1:0] fr;
  logic [FrW-1:0] rem;
  int lead;
  int scale;
  int regime;
  int regimeLen;
  int keep;
  int cut;
  int mask;

  always_comb begin
    mag = quire[QuireW-1] ? -quire : quire;
    lead = 0;
    for (int i = 0; i < QuireW; i++) begin
      if (mag[i]) begin
        lead = i;
      end
    end
    // Bits below the leading one
    fr = FrW'(mag << (QuireW - 1 - lead));
    scale = lead - QuireFrac;
    regime = scale >>> ES;
    regimeLen = (regime >= 0) ? regime + 2 : 1 - regime;
    if (regimeLen > WIDTH - 1) begin
      regimeLen = WIDTH - 1;
    end
    keep = WIDTH - 1 - regimeLen - ES;
    rem = '0;
    cut = 0;
    mask = 0;

    out.isNaR = quireNaR;
    out.isZero = !quireNaR && (mag == '0);
    out.sign = quire[QuireW-1];
    out.scale = ScaleW'(scale);
    out.frac = '0;
    trailing = '0;
    sticky = 1'b0;

    if (scale >= MaxScale) begin
      out.scale = ScaleW'(MaxScale);
    end else if (scale < -MaxScale) begin
      // Below minpos, held at minpos
      out.scale = ScaleW'(-MaxScale);
    end else if (keep >= 0) begin
      rem = fr << keep;
      out.frac = fr[FrW-1 -: FracW] & ~({FracW{1'b1}} >> keep);
      trailing = rem[FrW-1 -: 2];
      sticky = |rem[FrW-3:0];
    end else begin
      // Neighbours are 2^s0 and 2^(s0 + 2^cut)
      cut = -keep;
      mask = (1 << cut) - 1;
      out.scale = ScaleW'(scale & ~mask);
      if ((scale & mask) == mask) begin
        // Midpoint sits at fraction bit 2^cut
        trailing[1] = (fr >> (FrW - (1 << cut))) != '0;
        trailing[0] = (fr >> (FrW - (1 << cut) + 1)) != '0;
        sticky = (fr << (1 << cut)) != '0;
      end
    end
  end

endmodule

// File: src/positRoundEncode.sv
`timescale 1ns/1ps
// Packs a decoded posit into its bit pattern with round to nearest even.
// Expects frac already cut to the bits that fit, trailing and sticky below it.
module positRoundEncode import quirePkg::*; #(
  parameter int WIDTH = 8,
  parameter int ES = 1
) (
  positUnpackedIf.snk      in,
  input  logic [1:0]       trailing,
  input  logic             sticky,
  output logic [WIDTH-1:0] out
);

  localparam int ScaleW = scaleBits(WIDTH, ES);
  localparam int FracW = fracBits(WIDTH, ES);
  localparam int FullW = WIDTH + ES + FracW;
  localparam int BodyW = WIDTH - 1;

  logic signed [ScaleW-1:0] regime;
  logic negRegime;
  logic [ES-1:0] expField;
  logic [FullW-1:0] full;
  logic [BodyW-1:0] body;
  logic roundUp;
  int runLen;

  always_comb begin
    regime = in.scale >>> ES;
    negRegime = regime < 0;
    expField = in.scale[ES-1:0];
    runLen = negRegime ? -int'(regime) : int'(regime) + 1;

    // Terminator, exponent and fraction, pushed right by the regime run
    full = {negRegime, expField, in.frac, {(WIDTH-1){1'b0}}} >> runLen;
    if (!negRegime) begin
      full = full | ~({FullW{1'b1}} >> runLen);
    end
    body = full[FullW-1 -: BodyW];

    roundUp = trailing[1] && (trailing[0] || sticky || body[0]);
    // Saturate at maxpos
    if (roundUp && body != '1) begin
      body = body + 1'b1;
    end
    // Nonzero values stay at least minpos
    if (body == '0) begin
      body = BodyW'(1);
    end

    if (in.isNaR) begin
      out = {1'b1, {(WIDTH-1){1'b0}}};
    end else if (in.isZero) begin
      out = '0;
    end else if (in.sign) begin
      out = -{1'b0, body};
    end else begin
      out = {1'b0, body};
    end
  end

endmodule

// File: src/quireDotApb.sv
`timescale 1ns/1ps
// Posit dot-product unit with an APB slave port.
// Write OPA and OPB, then CTRL to clear or accumulate; RESULT reads the rounded quire.
module quireDotApb import quirePkg::*; #(
  parameter int WIDTH = 8,
  parameter int ES = 1,
  parameter int OVERFLOW = 0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  localparam int QuireW = quireBits(WIDTH, ES, OVERFLOW);

  logic [WIDTH-1:0] opA;
  logic [WIDTH-1:0] opB;
  logic [WIDTH-1:0] result;
  logic access;
  logic addrHit;
  logic wrEn;
  logic ctrlWr;
  logic clear;
  logic acc;
  logic signed [QuireW-1:0] term;
  logic signed [QuireW-1:0] quire;
  logic termNaR;
  logic quireNaR;
  logic [1:0] trailing;
  logic sticky;

  positUnpackedIf #(.WIDTH(WIDTH), .ES(ES)) unpA ();
  positUnpackedIf #(.WIDTH(WIDTH), .ES(ES)) unpB ();
  positUnpackedIf #(.WIDTH(WIDTH), .ES(ES)) unpQ ();

  // No wait states
  assign pready = 1'b1;
  assign access = psel && penable && pready;
  assign addrHit = paddr inside {RegOpA, RegOpB, RegCtrl, RegResult};
  assign pslverr = access && (!addrHit || (pwrite && paddr == RegResult));
  assign wrEn = access && pwrite && !pslverr;
  assign ctrlWr = wrEn && (paddr == RegCtrl);
  assign clear = ctrlWr && pwdata[CtrlClear];
  assign acc = ctrlWr && pwdata[CtrlAcc];

  always_ff @(posedge clk) begin
    if (rst) begin
      opA <= '0;
      opB <= '0;
    end else if (wrEn) begin
      if (paddr == RegOpA) begin
        opA <= pwdata[WIDTH-1:0];
      end
      if (paddr == RegOpB) begin
        opB <= pwdata[WIDTH-1:0];
      end
    end
  end

  // CTRL reads as zero
  always_comb begin
    case (paddr)
      RegOpA:    prdata = 32'(opA);
      RegOpB:    prdata = 32'(opB);
      RegResult: prdata = 32'(result);
      default:   prdata = '0;
    endcase
  end

  positDecode #(.WIDTH(WIDTH), .ES(ES)) decA (.in(opA), .out(unpA));
  positDecode #(.WIDTH(WIDTH), .ES(ES)) decB (.in(opB), .out(unpB));

  positMulQuire #(.WIDTH(WIDTH), .ES(ES), .OVERFLOW(OVERFLOW)) mul (
    .a(unpA),
    .b(unpB),
    .term,
    .termNaR
  );

  quireAccum #(.WIDTH(WIDTH), .ES(ES), .OVERFLOW(OVERFLOW)) accum (
    .clk,
    .rst,
    .clear,
    .acc,
    .term,
    .termNaR,
    .quire,
    .quireNaR
  );

  quireToPosit #(.WIDTH(WIDTH), .ES(ES), .OVERFLOW(OVERFLOW)) norm (
    .quire,
    .quireNaR,
    .out(unpQ),
    .trailing,
    .sticky
  );

  positRoundEncode #(.WIDTH(WIDTH), .ES(ES)) enc (
    .in(unpQ),
    .trailing,
    .sticky,
    .out(result)
  );

endmodule

// File: dv/quireDot_properties.sv
`timescale 1ns/1ps
// APB and quire assertions for the dot-product unit.
// Bound into every quireDotApb instance.
module quireDotProps (
  input logic clk,
  input logic rst,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic clear,
  input logic quireNaR
);

  // No wait states ever
  readyHigh: assert property (@(posedge clk) pready)
    else $error("pready went low");

  // Errors only in an access phase that follows its setup phase
  errInAccess: assert property (@(posedge clk) disable iff (rst)
    pslverr |-> psel && penable && $past(psel && !penable))
    else $error("pslverr high outside the access phase");

  // NaR only drops on a clear
  narSticky: assert property (@(posedge clk) disable iff (rst) $fell(quireNaR) |-> $past(clear))
    else $error("quireNaR fell without a clear");

endmodule

bind quireDotApb quireDotProps props (.*);

// File: dv/quireDotTb.sv
`timescale 1ns/1ps
// Testbench for the posit dot-product unit, driven through its APB port.
// A table of all posit values feeds a real-valued reference for RESULT.
module quireDotTb import quirePkg::*; ();

  localparam int Width = 8;
  localparam int Es = 1;
  localparam int Seed = 48515;
  localparam int PlannedXfers = 300 * 5 + 40 * (2 + 3 * 16) + 100;
  localparam int TimeoutCycles = 20 * PlannedXfers;
  localparam logic [Width-1:0] NarPat = {1'b1, {(Width-1){1'b0}}};
  localparam logic [Width-1:0] MinPos = Width'(1);
  localparam logic [Width-1:0] MaxPos = {1'b0, {(Width-1){1'b1}}};

  logic clk;
  logic rst;
  logic psel;
  logic penable;
  logic pwrite;
  logic [7:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;

  real posVal [2**Width];
  logic [Width-1:0] seqA [$];
  logic [Width-1:0] seqB [$];
  logic [Width-1:0] expQ [$];
  string nameQ [$];
  logic [Width-1:0] expNow;
  string nameNow;
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  quireDotApb #(.WIDTH(Width), .ES(Es), .OVERFLOW(0)) dut_i (
    .clk,
    .rst,
    .psel,
    .penable,
    .pwrite,
    .paddr,
    .pwdata,
    .prdata,
    .pready,
    .pslverr
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Value of a posit pattern from regime, exponent and fraction
  function automatic real posToReal(input logic [Width-1:0] p);
    logic [Width-1:0] m;
    logic first;
    int i;
    int run;
    int e;
    real f;
    real w;
    m = p[Width-1] ? -p : p;
    first = m[Width-2];
    run = 0;
    i = Width - 2;
    while (i >= 0 && m[i] == first) begin
      run++;
      i--;
    end
    // Skip the terminator
    i--;
    e = 0;
    for (int j = 0; j < Es; j++) begin
      e = e << 1;
      if (i >= 0) begin
        e = e | int'(m[i]);
        i--;
      end
    end
    f = 1.0;
    w = 0.5;
    while (i >= 0) begin
      if (m[i]) begin
        f = f + w;
      end
      w = w / 2.0;
      i--;
    end
    e = (first ? run - 1 : -run) * (1 << Es) + e;
    return (p[Width-1] ? -f : f) * (2.0 ** e);
  endfunction

  // Exact sum of products, then nearest posit with ties to the even pattern
  function automatic logic [Width-1:0] refDot(input logic [Width-1:0] qa [$],
                                              input logic [Width-1:0] qb [$]);
    real sum;
    real mag;
    real d;
    real bestD;
    logic [Width-1:0] best;
    sum = 0.0;
    foreach (qa[i]) begin
      if (qa[i] == NarPat || qb[i] == NarPat) begin
        return NarPat;
      end
      sum = sum + posVal[qa[i]] * posVal[qb[i]];
    end
    if (sum == 0.0) begin
      return '0;
    end
    mag = (sum < 0.0) ? -sum : sum;
    best = MinPos;
    bestD = (mag > posVal[1]) ? mag - posVal[1] : posVal[1] - mag;
    for (int p = 2; p < 2**(Width-1); p++) begin
      d = (mag > posVal[p]) ? mag - posVal[p] : posVal[p] - mag;
      if (d < bestD || (d == bestD && p % 2 == 0)) begin
        best = Width'(p);
        bestD = d;
      end
    end
    return (sum < 0.0) ? -best : best;
  endfunction

  // Keeps long sums exact in double and inside the quire range
  function automatic logic [Width-1:0] moderateOperand();
    logic [Width-1:0] p;
    real m;
    do begin
      p = Width'($urandom);
      m = (posVal[p] < 0.0) ? -posVal[p] : posVal[p];
    end while (p == NarPat || (p != '0 && (m < 2.0 ** (-6) || m > 2.0 ** 6)));
    return p;
  endfunction

  function automatic logic [Width-1:0] findPattern(input real v);
    for (int p = 1; p < 2**(Width-1); p++) begin
      if (posVal[p] == v) begin
        return Width'(p);
      end
    end
    $display("No posit pattern holds the tie step value %f", v);
    errors++;
    return '0;
  endfunction

  task automatic apbXfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                         output logic [31:0] rdata, output logic err);
    @(posedge clk);
    #1;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    while (!pready) begin
      @(negedge clk);
    end
    rdata = prdata;
    err = pslverr;
    @(posedge clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic err;
    apbXfer(1'b1, addr, data, rd, err);
    if (err) begin
      $display("Unexpected pslverr on write to address %h", addr);
      errors++;
    end
  endtask

  task automatic apbRead(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apbXfer(1'b0, addr, 32'h0, data, err);
    if (err) begin
      $display("Unexpected pslverr on read from address %h", addr);
      errors++;
    end
  endtask

  task automatic checkReg(input string name, input logic [7:0] addr, input logic [Width-1:0] exp);
    logic [31:0] rd;
    apbRead(addr, rd);
    checks++;
    if (rd[Width-1:0] !== exp) begin
      $display("** Error [%s] expected %h, actual %h", name, exp, rd[Width-1:0]);
      errors++;
    end
  endtask

  task automatic checkSlvErr(input string name, input logic write, input logic [7:0] addr);
    logic [31:0] rd;
    logic err;
    apbXfer(write, addr, 32'h7F, rd, err);
    checks++;
    if (!err) begin
      $display("Access %s to address %h did not raise pslverr", name, addr);
      errors++;
    end
  endtask

  task automatic doClear();
    apbWrite(RegCtrl, 32'(1) << CtrlClear);
    seqA.delete();
    seqB.delete();
  endtask

  task automatic doAcc(input logic [Width-1:0] a, input logic [Width-1:0] b);
    apbWrite(RegOpA, 32'(a));
    apbWrite(RegOpB, 32'(b));
    apbWrite(RegCtrl, 32'(1) << CtrlAcc);
    seqA.push_back(a);
    seqB.push_back(b);
  endtask

  // The monitor below compares the read against the queued value
  task automatic expectResult(input string name, input logic [Width-1:0] exp);
    logic [31:0] rd;
    expQ.push_back(exp);
    nameQ.push_back(name);
    apbRead(RegResult, rd);
  endtask

  task automatic checkResult(input string name);
    expectResult(name, refDot(seqA, seqB));
  endtask

  // RESULT comparison in the access phase
  always @(negedge clk) begin
    if (psel && penable && pready && !pwrite && paddr == RegResult) begin
      if (expQ.size() == 0) begin
        $display("RESULT was read with no expected value queued");
        errors++;
      end else begin
        expNow = expQ.pop_front();
        nameNow = nameQ.pop_front();
        checks++;
        if (prdata[Width-1:0] !== expNow) begin
          $display("** Error [%s] expected %h, actual %h", nameNow, expNow, prdata[Width-1:0]);
          errors++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TimeoutCycles) begin
      $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    logic [Width-1:0] tieStep;
    int len;
    void'($urandom(Seed));
    rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    for (int p = 0; p < 2**Width; p++) begin
      posVal[p] = posToReal(Width'(p));
    end
    posVal[0] = 0.0;
    posVal[NarPat] = 0.0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // Register file and error responses
    expectResult("resetResult", '0);
    apbWrite(RegOpA, 32'h5A);
    checkReg("opA", RegOpA, 8'h5A);
    apbWrite(RegOpB, 32'hA5);
    checkReg("opB", RegOpB, 8'hA5);
    doClear();
    doAcc(8'h48, 8'h30);
    checkSlvErr("unmappedWrite", 1'b1, 8'h10);
    checkSlvErr("unmappedRead", 1'b0, 8'h14);
    checkSlvErr("resultWrite", 1'b1, RegResult);
    checkReg("opAKept", RegOpA, 8'h48);
    checkReg("opBKept", RegOpB, 8'h30);
    checkResult("resultKept");

    for (int n = 0; n < 300; n++) begin
      doClear();
      doAcc(Width'($urandom), Width'($urandom));
      checkResult($sformatf("single%0d", n));
    end

    for (int n = 0; n < 40; n++) begin
      doClear();
      len = 2 + int'($urandom % 15);
      for (int k = 0; k < len; k++) begin
        doAcc(moderateOperand(), moderateOperand());
      end
      checkResult($sformatf("dot%0d", n));
    end

    doClear();
    doAcc(8'h00, 8'h5B);
    expectResult("zeroTimesA", '0);
    doAcc(8'h5B, 8'h00);
    expectResult("zeroTimesB", '0);
    doClear();
    doAcc(NarPat, 8'h40);
    expectResult("narProduct", NarPat);
    doAcc(8'h40, 8'h40);
    expectResult("narSticky", NarPat);
    doClear();
    expectResult("narCleared", '0);
    doAcc(8'h40, 8'h40);
    apbWrite(RegCtrl, 32'h3);
    expectResult("clearWins", '0);

    // Rounding at both ends of the range and at exact midpoints
    doClear();
    doAcc(MinPos, MinPos);
    expectResult("minposSquared", MinPos);
    doClear();
    doAcc(MaxPos, MaxPos);
    expectResult("maxposSquared", MaxPos);
    tieStep = findPattern((posVal[8'h41] - posVal[8'h40]) / 2.0);
    doClear();
    doAcc(8'h40, 8'h40);
    doAcc(tieStep, 8'h40);
    expectResult("tieDown", 8'h40);
    doClear();
    doAcc(8'h41, 8'h40);
    doAcc(tieStep, 8'h40);
    expectResult("tieUp", 8'h42);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: quireDot.f
src/quirePkg.sv
src/positUnpackedIf.sv
src/positDecode.sv
src/positMulQuire.sv
src/quireAccum.sv
src/quireToPosit.sv
src/positRoundEncode.sv
src/quireDotApb.sv
dv/quireDot_properties.sv
dv/quireDotTb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP ?= quireDotTb
FILELIST ?= quireDot.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
